/* hdl/touch_cfg.svh */
//==========================================================================
// host command bytes, frame tags and MPR121 register map
// recommended setup table and read-back hold time
//==========================================================================
`ifndef TOUCH_CFG_SVH
`define TOUCH_CFG_SVH

// host command bytes
`define TOUCH_CMD_RUN        8'h52 // 'R'
`define TOUCH_CMD_STOP       8'h53 // 'S'
`define TOUCH_CMD_READ_REG   8'h6D // 'm'

// frame tags
`define TOUCH_TAG_STATUS     8'hBB
`define TOUCH_TAG_READBACK   8'h6D

// MPR121 registers
`define MPR_STATUS0_ADDR     8'h00 // ele0..ele7
`define MPR_STATUS1_ADDR     8'h01 // ele8..ele11 in low nibble
`define MPR_ELE_CONFIG_ADDR  8'h5E
`define MPR_ELE_RUN_VALUE    8'h8F // all 12 electrodes scanning
`define MPR_ELE_STOP_VALUE   8'h00

// setup table in write order
`define MPR_SETUP_LEN        14
`define MPR_SETUP_ADDR_0     8'h2B // MHD rising
`define MPR_SETUP_DATA_0     8'h01
`define MPR_SETUP_ADDR_1     8'h2C // NHD rising
`define MPR_SETUP_DATA_1     8'h01
`define MPR_SETUP_ADDR_2     8'h2D // NCL rising
`define MPR_SETUP_DATA_2     8'h0E
`define MPR_SETUP_ADDR_3     8'h2E // FDL rising
`define MPR_SETUP_DATA_3     8'h00
`define MPR_SETUP_ADDR_4     8'h2F // MHD falling
`define MPR_SETUP_DATA_4     8'h01
`define MPR_SETUP_ADDR_5     8'h30 // NHD falling
`define MPR_SETUP_DATA_5     8'h05
`define MPR_SETUP_ADDR_6     8'h31 // NCL falling
`define MPR_SETUP_DATA_6     8'h01
`define MPR_SETUP_ADDR_7     8'h32 // FDL falling
`define MPR_SETUP_DATA_7     8'h00
`define MPR_SETUP_ADDR_8     8'h33 // NHD touched
`define MPR_SETUP_DATA_8     8'h00
`define MPR_SETUP_ADDR_9     8'h34 // NCL touched
`define MPR_SETUP_DATA_9     8'h00
`define MPR_SETUP_ADDR_10    8'h35 // FDL touched
`define MPR_SETUP_DATA_10    8'h00
`define MPR_SETUP_ADDR_11    8'h5B // debounce
`define MPR_SETUP_DATA_11    8'h00
`define MPR_SETUP_ADDR_12    8'h5C // filter / CDC config
`define MPR_SETUP_DATA_12    8'h10
`define MPR_SETUP_ADDR_13    8'h5D // filter / CDT config
`define MPR_SETUP_DATA_13    8'h20

// idle cycles after a single register read
`define MPR_READBACK_HOLD    6

`endif

/* hdl/touch_pkg.sv */
//==========================================================================
// shared types: host opcodes, FSM states, register byte, touch status
// and the 32-bit host frame
//==========================================================================
`include "touch_cfg.svh"

package touch_pkg;

	typedef logic [7:0]  reg_byte_t;     // MPR121 address or data byte
	typedef logic [11:0] touch_status_t; // one bit per electrode

	// host command bytes
	typedef enum logic [7:0] {
		OP_RUN      = `TOUCH_CMD_RUN,
		OP_STOP     = `TOUCH_CMD_STOP,
		OP_READ_REG = `TOUCH_CMD_READ_REG
	} uart_opcode_e;

	// sequencer
	typedef enum logic [2:0] {
		CORE_IDLE,
		CORE_WAIT_INIT, // waiting on agent readiness
		CORE_CHIP_SET,
		CORE_STANDBY,
		CORE_READING
	} core_state_e;

	// MPR121 controller
	typedef enum logic [4:0] {
		MPR_IDLE,
		MPR_SETUP,     // setup table walk
		MPR_RUN,       // scan start write
		MPR_STOP,      // scan stop write
		MPR_READ,      // single register read
		MPR_READ_HOLD,
		MPR_POLL,      // status register poll
		MPR_BUS_EN,    // shared write/read transfer
		MPR_BUS_ACK,
		MPR_BUS_WAIT,
		MPR_ERROR
	} mpr_state_e;

	// host frame, pad byte is always zero
	typedef struct packed {
		reg_byte_t tag;
		reg_byte_t hi;
		reg_byte_t lo;
		reg_byte_t pad;
	} tx_frame_t;

endpackage

/* hdl/uart_cmd_decoder.sv */
//==========================================================================
// host command decoder: run level and register-read requests
//==========================================================================
`timescale 1ns/1ps

module uart_cmd_decoder
	import touch_pkg::*;
(
	input  logic        i_CLK,
	input  logic        i_RST,
	input  logic [15:0] i_uart_rx_data,  // opcode [15:8], reg addr [7:0]
	input  logic        i_uart_rx_valid, // one-cycle pulse
	output logic        o_run_mode,      // set by RUN, cleared by STOP
	output logic        o_read_req,      // one-cycle pulse
	output reg_byte_t   o_read_addr      // held until next read command
);

	logic [15:0]  r_cmd_word; // captured command
	logic         r_cmd_vld;  // decode next cycle
	uart_opcode_e w_opcode;

	assign w_opcode = uart_opcode_e'(r_cmd_word[15:8]);

	// command word and read address
	always_ff @(posedge i_CLK) begin
		if (i_uart_rx_valid)
			r_cmd_word <= i_uart_rx_data;
		if (r_cmd_vld && w_opcode == OP_READ_REG)
			o_read_addr <= r_cmd_word[7:0];
	end

	// capture edge, then decode edge
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_cmd_vld  <= 1'b0;
			o_run_mode <= 1'b0;
			o_read_req <= 1'b0;
		end else begin
			r_cmd_vld  <= i_uart_rx_valid;
			o_read_req <= 1'b0;
			if (r_cmd_vld) begin
				case (w_opcode)
					OP_RUN:      o_run_mode <= 1'b1;
					OP_STOP:     o_run_mode <= 1'b0;
					OP_READ_REG: o_read_req <= 1'b1;
					default:     o_read_req <= 1'b0; // unknown bytes are ignored
				endcase
			end
		end
	end

endmodule

/* hdl/touch_sequencer.sv */
//==========================================================================
// core sequencer: init wait, one-time setup, run and read-back arbitration
//==========================================================================
`timescale 1ns/1ps

module touch_sequencer
	import touch_pkg::*;
(
	input  logic      i_CLK,
	input  logic      i_RST,
	input  logic      i_mpr_init_set, // agent ready
	input  logic      i_run_mode,
	input  logic      i_read_req,
	input  reg_byte_t i_read_addr,
	input  logic      i_setup_done,
	input  logic      i_scan_active,
	input  logic      i_ctrl_idle,
	output logic      o_setup_start,  // pulse
	output logic      o_run_enable,   // level
	output logic      o_read_start,   // pulse
	output reg_byte_t o_start_addr,
	output logic      o_chip_set,
	output logic      o_run_set,
	output logic      o_core_busy
);

	core_state_e r_state;
	logic        r_read_pend; // read request waiting for an idle controller

	// address of the latched read request
	always_ff @(posedge i_CLK) begin
		if (i_read_req)
			o_start_addr <= i_read_addr;
	end

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state       <= CORE_IDLE;
			r_read_pend   <= 1'b0;
			o_setup_start <= 1'b0;
			o_run_enable  <= 1'b0;
			o_read_start  <= 1'b0;
			o_chip_set    <= 1'b0;
			o_run_set     <= 1'b0;
			o_core_busy   <= 1'b0;
		end else begin
			o_setup_start <= 1'b0;
			o_read_start  <= 1'b0;
			o_chip_set    <= i_setup_done;  // system flags
			o_run_set     <= i_scan_active;
			case (r_state)
				CORE_IDLE: r_state <= CORE_WAIT_INIT;
				CORE_WAIT_INIT: begin
					if (i_mpr_init_set) begin
						o_setup_start <= 1'b1; // only setup request after reset
						r_state       <= CORE_CHIP_SET;
					end
				end
				CORE_CHIP_SET: begin
					if (o_chip_set)
						r_state <= CORE_STANDBY;
				end
				CORE_STANDBY: begin
					o_run_enable <= i_run_mode;
					if (i_run_mode && o_run_set) begin
						o_core_busy <= 1'b1;
						r_state     <= CORE_READING;
					end else if (!i_run_mode && r_read_pend && i_ctrl_idle && !o_run_enable) begin
						o_read_start <= 1'b1; // hand the read to the controller
						r_read_pend  <= 1'b0;
					end
				end
				CORE_READING: begin
					if (!i_run_mode) begin // STOP received
						o_run_enable <= 1'b0;
						o_core_busy  <= 1'b0;
						r_state      <= CORE_STANDBY;
					end
				end
				default: r_state <= CORE_IDLE;
			endcase
			if (i_read_req)
				r_read_pend <= 1'b1; // served once stopped and idle
		end
	end

endmodule

/* hdl/mpr121_controller.sv */
//==========================================================================
// MPR121 controller: setup table, scan start/stop, status polling
// and single register reads over the byte-wide register bus
//==========================================================================
`timescale 1ns/1ps
`include "touch_cfg.svh"

module mpr121_controller
	import touch_pkg::*;
(
	input  logic          i_CLK,
	input  logic          i_RST,
	input  logic          i_setup_start,
	input  logic          i_run_enable,
	input  logic          i_read_start,
	input  reg_byte_t     i_start_addr,   // register for single read
	input  reg_byte_t     i_mpr_data_out, // read data, valid when busy falls
	input  logic          i_mpr_busy,
	input  logic          i_mpr_fail,
	output reg_byte_t     o_mpr_reg_addr,
	output reg_byte_t     o_mpr_data_in,
	output logic          o_mpr_write_en, // one-cycle pulse
	output logic          o_mpr_read_en,  // one-cycle pulse
	output logic          o_setup_done,   // sticky until reset
	output logic          o_scan_active,
	output logic          o_ctrl_idle,
	output touch_status_t o_touch_status,
	output logic          o_status_strobe,
	output logic          o_read_done,
	output reg_byte_t     o_read_data,
	output logic          o_touch_error   // sticky until reset
);

	mpr_state_e r_state;
	mpr_state_e r_caller;   // owner of the current bus transfer
	logic [3:0] r_set_idx;  // setup table index
	logic       r_stat_sel; // 0 status0 next, 1 status1 next
	reg_byte_t  r_stat_lo;  // ele0..ele7
	logic [2:0] r_hold_cnt; // read-back hold
	reg_byte_t  w_tbl_addr;
	reg_byte_t  w_tbl_data;

	assign o_ctrl_idle = (r_state == MPR_IDLE);

	//==========================================================================
	// setup table
	always_comb begin
		case (r_set_idx)
			4'd0:    {w_tbl_addr, w_tbl_data} = {`MPR_SETUP_ADDR_0, `MPR_SETUP_DATA_0};
			4'd1:    {w_tbl_addr, w_tbl_data} = {`MPR_SETUP_ADDR_1, `MPR_SETUP_DATA_1};
			4'd2:    {w_tbl_addr, w_tbl_data} = {`MPR_SETUP_ADDR_2, `MPR_SETUP_DATA_2};
			4'd3:    {w_tbl_addr, w_tbl_data} = {`MPR_SETUP_ADDR_3, `MPR_SETUP_DATA_3};
			4'd4:    {w_tbl_addr, w_tbl_data} = {`MPR_SETUP_ADDR_4, `MPR_SETUP_DATA_4};
			4'd5:    {w_tbl_addr, w_tbl_data} = {`MPR_SETUP_ADDR_5, `MPR_SETUP_DATA_5};
			4'd6:    {w_tbl_addr, w_tbl_data} = {`MPR_SETUP_ADDR_6, `MPR_SETUP_DATA_6};
			4'd7:    {w_tbl_addr, w_tbl_data} = {`MPR_SETUP_ADDR_7, `MPR_SETUP_DATA_7};
			4'd8:    {w_tbl_addr, w_tbl_data} = {`MPR_SETUP_ADDR_8, `MPR_SETUP_DATA_8};
			4'd9:    {w_tbl_addr, w_tbl_data} = {`MPR_SETUP_ADDR_9, `MPR_SETUP_DATA_9};
			4'd10:   {w_tbl_addr, w_tbl_data} = {`MPR_SETUP_ADDR_10, `MPR_SETUP_DATA_10};
			4'd11:   {w_tbl_addr, w_tbl_data} = {`MPR_SETUP_ADDR_11, `MPR_SETUP_DATA_11};
			4'd12:   {w_tbl_addr, w_tbl_data} = {`MPR_SETUP_ADDR_12, `MPR_SETUP_DATA_12};
			4'd13:   {w_tbl_addr, w_tbl_data} = {`MPR_SETUP_ADDR_13, `MPR_SETUP_DATA_13};
			default: {w_tbl_addr, w_tbl_data} = 16'h0000;
		endcase
	end

	//==========================================================================
	// controller FSM
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state         <= MPR_IDLE;
			r_caller        <= MPR_IDLE;
			r_set_idx       <= '0;
			r_stat_sel      <= 1'b0;
			r_stat_lo       <= '0;
			r_hold_cnt      <= '0;
			o_mpr_reg_addr  <= '0;
			o_mpr_data_in   <= '0;
			o_mpr_write_en  <= 1'b0;
			o_mpr_read_en   <= 1'b0;
			o_setup_done    <= 1'b0;
			o_scan_active   <= 1'b0;
			o_touch_status  <= '0;
			o_status_strobe <= 1'b0;
			o_read_done     <= 1'b0;
			o_read_data     <= '0;
			o_touch_error   <= 1'b0;
		end else begin
			o_mpr_write_en  <= 1'b0; // pulses
			o_mpr_read_en   <= 1'b0;
			o_status_strobe <= 1'b0;
			o_read_done     <= 1'b0;
			case (r_state)
				MPR_IDLE: begin
					if (i_setup_start && !o_setup_done) begin
						r_set_idx <= '0;
						r_state   <= MPR_SETUP;
					end else if (i_read_start)
						r_state <= MPR_READ;
					else if (i_run_enable)
						r_state <= o_scan_active ? MPR_POLL : MPR_RUN; // resume after error
					else if (o_scan_active)
						r_state <= MPR_STOP;
				end
				MPR_SETUP: begin
					if (r_set_idx == 4'(`MPR_SETUP_LEN)) begin
						o_setup_done <= 1'b1;
						r_state      <= MPR_IDLE;
					end else begin
						o_mpr_reg_addr <= w_tbl_addr;
						o_mpr_data_in  <= w_tbl_data;
						r_set_idx      <= r_set_idx + 4'd1;
						r_caller       <= MPR_SETUP;
						r_state        <= MPR_BUS_EN;
					end
				end
				MPR_RUN: begin
					o_mpr_reg_addr <= `MPR_ELE_CONFIG_ADDR;
					o_mpr_data_in  <= `MPR_ELE_RUN_VALUE;
					r_caller       <= MPR_RUN;
					r_state        <= MPR_BUS_EN;
				end
				MPR_STOP: begin
					o_mpr_reg_addr <= `MPR_ELE_CONFIG_ADDR;
					o_mpr_data_in  <= `MPR_ELE_STOP_VALUE;
					r_caller       <= MPR_STOP;
					r_state        <= MPR_BUS_EN;
				end
				MPR_READ: begin
					o_mpr_reg_addr <= i_start_addr;
					r_caller       <= MPR_READ;
					r_state        <= MPR_BUS_EN;
				end
				MPR_POLL: begin
					if (!i_run_enable)
						r_state <= MPR_STOP; // run dropped, disable electrodes
					else begin
						o_mpr_reg_addr <= r_stat_sel ? `MPR_STATUS1_ADDR : `MPR_STATUS0_ADDR;
						r_caller       <= MPR_POLL;
						r_state        <= MPR_BUS_EN;
					end
				end
				MPR_BUS_EN: begin
					if (r_caller == MPR_READ || r_caller == MPR_POLL)
						o_mpr_read_en <= 1'b1;
					else
						o_mpr_write_en <= 1'b1;
					r_state <= MPR_BUS_ACK;
				end
				MPR_BUS_ACK: r_state <= MPR_BUS_WAIT; // agent takes the enable here
				MPR_BUS_WAIT: begin
					if (!i_mpr_busy && i_mpr_fail)
						r_state <= MPR_ERROR;
					else if (!i_mpr_busy) begin
						case (r_caller)
							MPR_SETUP: r_state <= MPR_SETUP;
							MPR_RUN: begin
								o_scan_active <= 1'b1;
								r_stat_sel    <= 1'b0;
								r_state       <= MPR_POLL;
							end
							MPR_STOP: begin
								o_scan_active <= 1'b0;
								r_state       <= MPR_IDLE;
							end
							MPR_READ: begin
								o_read_done <= 1'b1;
								o_read_data <= i_mpr_data_out;
								r_hold_cnt  <= '0;
								r_state     <= MPR_READ_HOLD;
							end
							default: begin // status poll
								if (r_stat_sel) begin
									o_touch_status  <= {i_mpr_data_out[3:0], r_stat_lo};
									o_status_strobe <= 1'b1;
								end else
									r_stat_lo <= i_mpr_data_out;
								r_stat_sel <= !r_stat_sel;
								r_state    <= MPR_POLL;
							end
						endcase
					end
				end
				MPR_READ_HOLD: begin
					if (r_hold_cnt == 3'(`MPR_READBACK_HOLD - 1))
						r_state <= MPR_IDLE;
					else
						r_hold_cnt <= r_hold_cnt + 3'd1;
				end
				MPR_ERROR: begin
					o_touch_error <= 1'b1;
					r_state       <= MPR_IDLE;
				end
				default: r_state <= MPR_IDLE;
			endcase
		end
	end

endmodule

/* hdl/uart_frame_builder.sv */
//==========================================================================
// host frame builder: pending touch and read-back frames, touch first
//==========================================================================
`timescale 1ns/1ps
`include "touch_cfg.svh"

module uart_frame_builder
	import touch_pkg::*;
(
	input  logic          i_CLK,
	input  logic          i_RST,
	input  logic          i_status_strobe,
	input  touch_status_t i_touch_status,
	input  logic          i_read_done,
	input  reg_byte_t     i_read_data,
	input  reg_byte_t     i_read_addr,     // latched by the decoder
	input  logic          i_uart_tx_ready,
	output tx_frame_t     o_uart_tx_data,
	output logic          o_uart_tx_valid
);

	logic          r_touch_pend;
	logic          r_read_pend;
	touch_status_t r_touch;   // latest status only
	reg_byte_t     r_rb_addr;
	reg_byte_t     r_rb_data;

	// frame select, touch has priority
	always_comb begin
		o_uart_tx_data.pad = 8'h00;
		if (r_touch_pend) begin
			o_uart_tx_data.tag = `TOUCH_TAG_STATUS;
			o_uart_tx_data.hi  = {4'h0, r_touch[11:8]};
			o_uart_tx_data.lo  = r_touch[7:0];
		end else begin
			o_uart_tx_data.tag = `TOUCH_TAG_READBACK;
			o_uart_tx_data.hi  = r_rb_addr;
			o_uart_tx_data.lo  = r_rb_data;
		end
	end

	assign o_uart_tx_valid = i_uart_tx_ready && (r_touch_pend || r_read_pend);

	always_ff @(posedge i_CLK) begin
		if (i_status_strobe)
			r_touch <= i_touch_status; // overwrites unsent status
		if (i_read_done) begin
			r_rb_addr <= i_read_addr;
			r_rb_data <= i_read_data;
		end
	end

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_touch_pend <= 1'b0;
			r_read_pend  <= 1'b0;
		end else begin
			if (o_uart_tx_valid && r_touch_pend)
				r_touch_pend <= 1'b0;
			else if (o_uart_tx_valid)
				r_read_pend <= 1'b0;
			if (i_status_strobe)
				r_touch_pend <= 1'b1; // new status beats a release
			if (i_read_done)
				r_read_pend <= 1'b1;
		end
	end

endmodule

/* hdl/touch_sensor_top.sv */
//==========================================================================
// touch front end top: decoder, sequencer, MPR121 controller, frame builder
//==========================================================================
`timescale 1ns/1ps

module touch_sensor_top
	import touch_pkg::*;
(
	input  logic          i_CLK,
	input  logic          i_RST,
	// host link
	input  logic [15:0]   i_uart_rx_data,
	input  logic          i_uart_rx_valid,
	output tx_frame_t     o_uart_tx_data,
	output logic          o_uart_tx_valid,
	input  logic          i_uart_tx_ready,
	// MPR121 register bus
	input  reg_byte_t     i_mpr_data_out,
	output reg_byte_t     o_mpr_reg_addr,
	output reg_byte_t     o_mpr_data_in,
	output logic          o_mpr_write_en,
	output logic          o_mpr_read_en,
	input  logic          i_mpr_init_set,
	input  logic          i_mpr_busy,
	input  logic          i_mpr_fail,
	// system flags
	output logic          o_chip_set,
	output logic          o_run_set,
	output logic          o_core_busy,
	output touch_status_t o_touch_status,
	output logic          o_touch_error
);

	logic      w_run_mode;
	logic      w_read_req;
	reg_byte_t w_read_addr;   // decoder address, paired with read data
	logic      w_setup_start;
	logic      w_run_enable;
	logic      w_read_start;
	reg_byte_t w_start_addr;
	logic      w_setup_done;
	logic      w_scan_active;
	logic      w_ctrl_idle;
	logic      w_status_strobe;
	logic      w_read_done;
	reg_byte_t w_read_data;

	uart_cmd_decoder u_decoder (
		.i_CLK           (i_CLK),
		.i_RST           (i_RST),
		.i_uart_rx_data  (i_uart_rx_data),
		.i_uart_rx_valid (i_uart_rx_valid),
		.o_run_mode      (w_run_mode),
		.o_read_req      (w_read_req),
		.o_read_addr     (w_read_addr)
	);

	touch_sequencer u_sequencer (
		.i_CLK          (i_CLK),
		.i_RST          (i_RST),
		.i_mpr_init_set (i_mpr_init_set),
		.i_run_mode     (w_run_mode),
		.i_read_req     (w_read_req),
		.i_read_addr    (w_read_addr),
		.i_setup_done   (w_setup_done),
		.i_scan_active  (w_scan_active),
		.i_ctrl_idle    (w_ctrl_idle),
		.o_setup_start  (w_setup_start),
		.o_run_enable   (w_run_enable),
		.o_read_start   (w_read_start),
		.o_start_addr   (w_start_addr),
		.o_chip_set     (o_chip_set),
		.o_run_set      (o_run_set),
		.o_core_busy    (o_core_busy)
	);

	mpr121_controller u_mpr (
		.i_CLK           (i_CLK),
		.i_RST           (i_RST),
		.i_setup_start   (w_setup_start),
		.i_run_enable    (w_run_enable),
		.i_read_start    (w_read_start),
		.i_start_addr    (w_start_addr),
		.i_mpr_data_out  (i_mpr_data_out),
		.i_mpr_busy      (i_mpr_busy),
		.i_mpr_fail      (i_mpr_fail),
		.o_mpr_reg_addr  (o_mpr_reg_addr),
		.o_mpr_data_in   (o_mpr_data_in),
		.o_mpr_write_en  (o_mpr_write_en),
		.o_mpr_read_en   (o_mpr_read_en),
		.o_setup_done    (w_setup_done),
		.o_scan_active   (w_scan_active),
		.o_ctrl_idle     (w_ctrl_idle),
		.o_touch_status  (o_touch_status),
		.o_status_strobe (w_status_strobe),
		.o_read_done     (w_read_done),
		.o_read_data     (w_read_data),
		.o_touch_error   (o_touch_error)
	);

	uart_frame_builder u_frames (
		.i_CLK           (i_CLK),
		.i_RST           (i_RST),
		.i_status_strobe (w_status_strobe),
		.i_touch_status  (o_touch_status),
		.i_read_done     (w_read_done),
		.i_read_data     (w_read_data),
		.i_read_addr     (w_read_addr),
		.i_uart_tx_ready (i_uart_tx_ready),
		.o_uart_tx_data  (o_uart_tx_data),
		.o_uart_tx_valid (o_uart_tx_valid)
	);

endmodule

/* tb/tb_clock_gen.sv */
//==========================================================================
// testbench clock (20 ns period) and reset source
//==========================================================================
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #10 o_clk = ~o_clk; // 50 MHz
	end

	// reset held over the first 4 rising edges
	initial begin
		o_rst = 1'b1;
		repeat (4) @(posedge o_clk);
		o_rst <= 1'b0;
	end

endmodule

/* tb/tb_touch_top.sv */
//==========================================================================
// touch front end testbench: MPR121 bus model, host command driver,
// directed tests, compare tasks and watchdog
//==========================================================================
`timescale 1ns/1ps
`include "touch_cfg.svh"

module tb_touch_top
	import touch_pkg::*;
();

	//==========================================================================
	// run length budget in clock cycles
	localparam int CLK_NS   = 20;
	localparam int XFER_MAX = 16; // enable, ack, up to 8 busy, wait and return
	localparam int T_SETUP  = `MPR_SETUP_LEN * XFER_MAX + 40;
	localparam int T_RUN    = 8 * XFER_MAX + 40;
	localparam int T_STOP   = 2 * XFER_MAX + 140; // includes the quiet window
	localparam int T_READ   = 4 * (XFER_MAX + `MPR_READBACK_HOLD + 10);
	localparam int T_BACKP  = 16 * XFER_MAX + 120;
	localparam int T_FAIL   = 2 * (XFER_MAX + `MPR_READBACK_HOLD + 10) + 20;
	localparam int WATCHDOG_CYCLES =
		2 * (T_SETUP + T_RUN + T_STOP + T_READ + T_BACKP + T_FAIL + T_RUN + T_STOP);

	// recommended setup pairs in write order with the address in the upper byte
	localparam logic [223:0] SETUP_PAIRS = {
		16'h2B01, 16'h2C01, 16'h2D0E, 16'h2E00, 16'h2F01, 16'h3005, 16'h3101,
		16'h3200, 16'h3300, 16'h3400, 16'h3500, 16'h5B00, 16'h5C10, 16'h5D20
	};

	logic          clk;
	logic          rst;
	logic [15:0]   rx_data;
	logic          rx_valid;
	logic          tx_ready;
	tx_frame_t     tx_data;
	logic          tx_valid;
	reg_byte_t     mpr_data_out;
	reg_byte_t     mpr_reg_addr;
	reg_byte_t     mpr_data_in;
	logic          mpr_write_en;
	logic          mpr_read_en;
	logic          mpr_init_set;
	logic          mpr_busy;
	logic          mpr_fail;
	logic          chip_set;
	logic          run_set;
	logic          core_busy;
	touch_status_t touch_status;
	logic          touch_error;

	// bus model state
	reg_byte_t     regs [256];
	logic [15:0]   write_log [$];  // {addr, data} per completed write
	integer        seed = 71742;
	logic          fail_inject;
	logic [3:0]    busy_cnt;
	reg_byte_t     xfer_addr;
	logic          xfer_write;

	// host side capture
	tx_frame_t     frames [$];
	touch_status_t frame_touch [$]; // o_touch_status seen with each frame
	int            value_errors;
	int            other_errors;

	tb_clock_gen u_clk (
		.o_clk (clk),
		.o_rst (rst)
	);

	touch_sensor_top dut (
		.i_CLK           (clk),
		.i_RST           (rst),
		.i_uart_rx_data  (rx_data),
		.i_uart_rx_valid (rx_valid),
		.o_uart_tx_data  (tx_data),
		.o_uart_tx_valid (tx_valid),
		.i_uart_tx_ready (tx_ready),
		.i_mpr_data_out  (mpr_data_out),
		.o_mpr_reg_addr  (mpr_reg_addr),
		.o_mpr_data_in   (mpr_data_in),
		.o_mpr_write_en  (mpr_write_en),
		.o_mpr_read_en   (mpr_read_en),
		.i_mpr_init_set  (mpr_init_set),
		.i_mpr_busy      (mpr_busy),
		.i_mpr_fail      (mpr_fail),
		.o_chip_set      (chip_set),
		.o_run_set       (run_set),
		.o_core_busy     (core_busy),
		.o_touch_status  (touch_status),
		.o_touch_error   (touch_error)
	);

	//==========================================================================
	// MPR121 bus model
	always @(posedge clk) begin
		if (busy_cnt != 4'd0) begin
			busy_cnt <= busy_cnt - 4'd1;
			if (busy_cnt == 4'd1) begin // transfer ends with the outcome at busy fall
				mpr_busy <= 1'b0;
				mpr_fail <= fail_inject;
				if (!xfer_write)
					mpr_data_out <= regs[xfer_addr];
			end
		end else if (mpr_write_en || mpr_read_en) begin
			xfer_addr  <= mpr_reg_addr;
			xfer_write <= mpr_write_en;
			mpr_busy   <= 1'b1;
			mpr_fail   <= 1'b0;
			busy_cnt   <= 4'(3 + ($unsigned($random(seed)) % 6)); // 3..8 cycles
			if (mpr_write_en && !fail_inject) begin
				regs[mpr_reg_addr] <= mpr_data_in;
				write_log.push_back({mpr_reg_addr, mpr_data_in});
			end
		end
	end

	// host receiver samples the frame at the edge that takes it
	always @(posedge clk) begin
		if (tx_valid) begin
			frames.push_back(tx_data);
			frame_touch.push_back(touch_status);
			if (!tx_ready)
				report_failure("frame valid while the transmitter was not ready");
		end
	end

	//==========================================================================
	// compare tasks
	task automatic check_frame(input tx_frame_t got, input tx_frame_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAILED o_uart_tx_data: got %h expected %h", got, exp);
		end
	endtask

	task automatic check_touch(input touch_status_t got, input touch_status_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAILED o_touch_status: got %h expected %h", got, exp);
		end
	endtask

	task automatic check_write(input reg_byte_t got_addr, input reg_byte_t got_data,
		input reg_byte_t exp_addr, input reg_byte_t exp_data);
		if (got_addr !== exp_addr || got_data !== exp_data) begin
			value_errors++;
			$display("FAILED o_mpr_reg_addr/o_mpr_data_in: got %h/%h expected %h/%h",
				got_addr, got_data, exp_addr, exp_data);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		other_errors++;
		$display("ERROR: %s", msg);
	endtask

	//==========================================================================
	// host driver and waits
	task automatic send_cmd(input uart_opcode_e op, input reg_byte_t addr);
		@(posedge clk);
		rx_data  <= {op, addr};
		rx_valid <= 1'b1;
		@(posedge clk);
		rx_valid <= 1'b0;
	endtask

	function automatic logic read_flag(input string name);
		if (name == "o_chip_set")
			return chip_set;
		else if (name == "o_run_set")
			return run_set;
		else if (name == "o_core_busy")
			return core_busy;
		else
			return touch_error;
	endfunction

	task automatic wait_level(input string name, input logic level, input int limit);
		int n;
		n = 0;
		while (read_flag(name) !== level && n < limit) begin
			@(negedge clk); // outputs settled
			n++;
		end
		if (read_flag(name) !== level)
			report_failure($sformatf("%s did not reach %b within %0d cycles", name, level, limit));
	endtask

	task automatic wait_frames(input int count, input int limit, input string kind);
		int n;
		n = 0;
		while (frames.size() < count && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (frames.size() < count)
			report_failure($sformatf("no %s frame within %0d cycles", kind, limit));
	endtask

	task automatic check_last_write(input int base, input reg_byte_t addr, input reg_byte_t data);
		if (write_log.size() != base + 1)
			report_failure($sformatf("expected one register write, saw %0d", write_log.size() - base));
		else
			check_write(write_log[base][15:8], write_log[base][7:0], addr, data);
	endtask

	//==========================================================================
	// directed tests
	task automatic test_reset_setup();
		logic [15:0] exp;
		int          i;
		while (rst)
			@(negedge clk);
		check_flag("o_chip_set", chip_set, 1'b0);
		check_flag("o_run_set", run_set, 1'b0);
		check_flag("o_core_busy", core_busy, 1'b0);
		check_flag("o_touch_error", touch_error, 1'b0);
		check_flag("o_mpr_write_en", mpr_write_en, 1'b0);
		check_flag("o_mpr_read_en", mpr_read_en, 1'b0);
		check_flag("o_uart_tx_valid", tx_valid, 1'b0);
		@(posedge clk);
		mpr_init_set <= 1'b1; // agent ready
		wait_level("o_chip_set", 1'b1, T_SETUP);
		if (write_log.size() != 14)
			report_failure($sformatf("setup wrote %0d registers, not 14", write_log.size()));
		for (i = 0; i < 14 && i < write_log.size(); i++) begin
			exp = SETUP_PAIRS[(13 - i) * 16 +: 16];
			check_write(write_log[i][15:8], write_log[i][7:0], exp[15:8], exp[7:0]);
		end
	endtask

	task automatic test_run();
		int            base;
		int            i;
		touch_status_t exp_touch;
		regs[8'h00] = 8'h35;                    // ele0..ele7
		regs[8'h01] = 8'hF9;                    // upper nibble is not an electrode
		exp_touch   = {regs[8'h01][3:0], regs[8'h00]};
		base        = write_log.size();
		frames.delete();
		frame_touch.delete();
		send_cmd(OP_RUN, 8'h00);
		wait_level("o_run_set", 1'b1, T_RUN);
		check_last_write(base, 8'h5E, 8'h8F);
		wait_level("o_core_busy", 1'b1, 4); // sequencer enters READING
		wait_frames(3, T_RUN, "status");
		for (i = 0; i < 3 && i < frames.size(); i++) begin
			check_frame(frames[i], {8'hBB, 4'h0, exp_touch, 8'h00});
			check_touch(frame_touch[i], exp_touch);
		end
	endtask

	task automatic test_stop();
		int base;
		base = write_log.size();
		send_cmd(OP_STOP, 8'h00);
		wait_level("o_run_set", 1'b0, T_STOP);
		check_last_write(base, 8'h5E, 8'h00);
		check_flag("o_core_busy", core_busy, 1'b0);
		repeat (2) @(negedge clk);
		frames.delete();
		repeat (100) @(negedge clk); // quiet window
		if (frames.size() != 0)
			report_failure("status frames continued after STOP");
	endtask

	task automatic test_reg_read();
		reg_byte_t addr;
		int        i;
		for (i = 0; i < 4; i++) begin
			addr = $random(seed);
			frames.delete();
			send_cmd(OP_READ_REG, addr);
			wait_frames(1, T_READ / 4, "read-back");
			if (frames.size() > 0)
				check_frame(frames[0], {8'h6D, addr, regs[addr], 8'h00});
		end
	endtask

	task automatic test_back_pressure();
		int n;
		send_cmd(OP_RUN, 8'h00);
		wait_level("o_run_set", 1'b1, T_RUN);
		frames.delete();
		wait_frames(1, T_RUN, "status");
		@(posedge clk);
		tx_ready <= 1'b0;
		@(negedge clk);
		frames.delete();
		regs[8'h00] = 8'hA6; // first update to be overwritten
		regs[8'h01] = 8'h02;
		repeat (6 * XFER_MAX) @(negedge clk);
		regs[8'h00] = 8'h5C; // latest status
		regs[8'h01] = 8'h0B;
		n = 0;
		while (touch_status !== 12'hB5C && n < 8 * XFER_MAX) begin
			@(negedge clk);
			n++;
		end
		check_touch(touch_status, 12'hB5C);
		repeat (2) @(negedge clk);
		if (frames.size() != 0)
			report_failure("frame left while the transmitter was not ready");
		frames.delete();
		@(posedge clk);
		tx_ready <= 1'b1;
		wait_frames(1, 4, "held status");
		if (frames.size() > 0)
			check_frame(frames[0], {8'hBB, 8'h0B, 8'h5C, 8'h00});
		send_cmd(OP_STOP, 8'h00);
		wait_level("o_run_set", 1'b0, T_STOP);
	endtask

	task automatic test_bus_failure();
		fail_inject = 1'b1;
		frames.delete();
		send_cmd(OP_READ_REG, 8'h5C);
		wait_level("o_touch_error", 1'b1, T_FAIL / 2);
		fail_inject = 1'b0;
		if (frames.size() != 0)
			report_failure("read-back frame sent for a failed transfer");
		send_cmd(OP_READ_REG, 8'h2D); // clean read afterwards
		wait_frames(1, T_FAIL / 2, "read-back");
		if (frames.size() > 0)
			check_frame(frames[0], {8'h6D, 8'h2D, regs[8'h2D], 8'h00});
		check_flag("o_touch_error", touch_error, 1'b1); // sticky
	endtask

	//==========================================================================
	// main sequence
	initial begin
		int i;
		rx_data      = '0;
		rx_valid     = 1'b0;
		tx_ready     = 1'b1;
		mpr_init_set = 1'b0;
		mpr_busy     = 1'b0;
		mpr_fail     = 1'b0;
		mpr_data_out = '0;
		fail_inject  = 1'b0;
		busy_cnt     = '0;
		xfer_addr    = '0;
		xfer_write   = 1'b0;
		value_errors = 0;
		other_errors = 0;
		for (i = 0; i < 256; i++)
			regs[i] = reg_byte_t'(i) ^ 8'h5A; // every address bit shows
		test_reset_setup();
		test_run();
		test_stop();
		test_reg_read();
		test_back_pressure();
		test_bus_failure();
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// watchdog at twice the summed worst case
	initial begin
		#(WATCHDOG_CYCLES * CLK_NS);
		$display("watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+hdl
hdl/touch_pkg.sv
hdl/uart_cmd_decoder.sv
hdl/touch_sequencer.sv
hdl/mpr121_controller.sv
hdl/uart_frame_builder.sv
hdl/touch_sensor_top.sv
tb/tb_clock_gen.sv
tb/tb_touch_top.sv
